// File: design/vdec_pkg.sv
// Shared encodings for the vector decoder, a subset of RVV 1.0
// Only the funct6 codes listed here decode as valid, everything else is rejected
package vdec_pkg;

    // Width of vl and evl
    localparam int VL_W = 16;

    // Major opcodes, AMO left out
    typedef enum logic [6:0] {
        VMOC_NONE    = 7'b0000000,
        VMOC_LOAD    = 7'b0000111,
        VMOC_STORE   = 7'b0100111,
        VMOC_ALU_CFG = 7'b1010111
    } vmajor_t;

    // Arithmetic formats from funct3
    typedef enum logic [2:0] {
        OPIVV, OPFVV, OPMVV, OPIVI, OPIVX, OPFVF, OPMVX, OPCFG
    } vfunct3_t;

    // Memory addressing modes
    typedef enum logic [1:0] {
        MOP_UNIT, MOP_UINDEXED, MOP_STRIDED, MOP_OINDEXED
    } mop_t;

    // Unit-stride variants, same codes for loads and stores
    typedef enum logic [4:0] {
        LUMOP_UNIT         = 5'b00000,
        LUMOP_UNIT_FULLREG = 5'b01000,
        LUMOP_UNIT_MASK    = 5'b01011
    } lumop_t;

    typedef enum logic [2:0] {
        WIDTH8 = 3'b000, WIDTH16 = 3'b101, WIDTH32 = 3'b110
    } width_t;

    // Element width as log2(SEW/8)
    typedef enum logic [1:0] {SEW8, SEW16, SEW32, SEW64} vsew_t;

    typedef enum logic [5:0] {
        VADD = 6'b000000, VSUB = 6'b000010, VRSUB = 6'b000011,
        VMINU = 6'b000100, VMIN = 6'b000101, VMAXU = 6'b000110, VMAX = 6'b000111,
        VAND = 6'b001001, VOR = 6'b001010, VXOR = 6'b001011, VSLIDEUP = 6'b001110,
        VSLL = 6'b100101, VSRL = 6'b101000, VSRA = 6'b101001,
        VNSRL = 6'b101100, VNSRA = 6'b101101, VNCLIPU = 6'b101110, VNCLIP = 6'b101111
    } vopi_t;

    typedef enum logic [5:0] {
        VREDSUM = 6'b000000, VREDAND = 6'b000001, VREDOR = 6'b000010,
        VWXUNARY0 = 6'b010000, VMULHU = 6'b100100, VMUL = 6'b100101,
        VMADD = 6'b101001, VNMSUB = 6'b101011, VMACC = 6'b101101, VNMSAC = 6'b101111,
        VWADDU = 6'b110000, VWADD = 6'b110001
    } vopm_t;

    typedef enum logic [2:0] {VFU_ALU, VFU_RED, VFU_MUL, VFU_MSK, VFU_PRM} vfu_t;

    // Operation codes, read per unit
    // ALU uses ADD..CLIP, SR is logical when unsigned
    // Multiplier uses MUL, MULH, and ADD/SUB to accumulate into vd, MADD/NMSUB into vs2
    // Reduction reuses ADD/AND/OR, permute uses SLL for slide up, mask unit uses MOVE
    typedef enum logic [3:0] {
        VALU_ADD, VALU_SUB, VALU_RSUB, VALU_MIN, VALU_MAX, VALU_AND, VALU_OR, VALU_XOR,
        VALU_SLL, VALU_SR, VALU_CLIP, VALU_MUL, VALU_MULH, VALU_MADD, VALU_NMSUB, VALU_MOVE
    } valuop_t;

    typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} vsetvl_t;

endpackage

// File: design/vopi_decode.sv
// OPI funct6 decode, valid only for the codes in vdec_pkg::vopi_t
// Caller qualifies the result with the funct3 format
`timescale 1ns/1ps

module vopi_decode (
    input  vdec_pkg::vopi_t   funct6,
    output vdec_pkg::vfu_t    vfu,
    output vdec_pkg::valuop_t op,
    output logic              opunsigned,
    output logic              valid
);

    always_comb begin
        // Most OPI codes go to the ALU as signed ops
        vfu        = vdec_pkg::VFU_ALU;
        op         = vdec_pkg::VALU_ADD;
        opunsigned = 1'b0;
        valid      = 1'b1;
        case (funct6)
            vdec_pkg::VADD:  op = vdec_pkg::VALU_ADD;
            vdec_pkg::VSUB:  op = vdec_pkg::VALU_SUB;
            vdec_pkg::VRSUB: op = vdec_pkg::VALU_RSUB;
            vdec_pkg::VMINU: begin
                op         = vdec_pkg::VALU_MIN;
                opunsigned = 1'b1;
            end
            vdec_pkg::VMIN:  op = vdec_pkg::VALU_MIN;
            vdec_pkg::VMAXU: begin
                op         = vdec_pkg::VALU_MAX;
                opunsigned = 1'b1;
            end
            vdec_pkg::VMAX:  op = vdec_pkg::VALU_MAX;
            vdec_pkg::VAND:  op = vdec_pkg::VALU_AND;
            vdec_pkg::VOR:   op = vdec_pkg::VALU_OR;
            vdec_pkg::VXOR:  op = vdec_pkg::VALU_XOR;
            vdec_pkg::VSLL:  op = vdec_pkg::VALU_SLL;
            // Logical right shifts, narrowing form differs only in eew
            vdec_pkg::VSRL, vdec_pkg::VNSRL: begin
                op         = vdec_pkg::VALU_SR;
                opunsigned = 1'b1;
            end
            vdec_pkg::VSRA, vdec_pkg::VNSRA: op = vdec_pkg::VALU_SR;
            vdec_pkg::VNCLIPU: begin
                op         = vdec_pkg::VALU_CLIP;
                opunsigned = 1'b1;
            end
            vdec_pkg::VNCLIP: op = vdec_pkg::VALU_CLIP;
            // Slide up moves elements to higher indices
            vdec_pkg::VSLIDEUP: begin
                vfu = vdec_pkg::VFU_PRM;
                op  = vdec_pkg::VALU_SLL;
            end
            default: valid = 1'b0;
        endcase
    end

endmodule

// File: design/vopm_decode.sv
// OPM funct6 decode, valid only for the codes in vdec_pkg::vopm_t
// Caller qualifies the result with the funct3 format
`timescale 1ns/1ps

module vopm_decode (
    input  vdec_pkg::vopm_t   funct6,
    output vdec_pkg::vfu_t    vfu,
    output vdec_pkg::valuop_t op,
    output logic              opunsigned,
    output logic              valid
);

    always_comb begin
        vfu        = vdec_pkg::VFU_MUL;
        op         = vdec_pkg::VALU_MUL;
        opunsigned = 1'b0;
        valid      = 1'b1;
        case (funct6)
            // Reductions fold with the plain ALU op
            vdec_pkg::VREDSUM: begin
                vfu = vdec_pkg::VFU_RED;
                op  = vdec_pkg::VALU_ADD;
            end
            vdec_pkg::VREDAND: begin
                vfu = vdec_pkg::VFU_RED;
                op  = vdec_pkg::VALU_AND;
            end
            vdec_pkg::VREDOR: begin
                vfu = vdec_pkg::VFU_RED;
                op  = vdec_pkg::VALU_OR;
            end
            // Scalar move, vcpop and vfirst; vs1 field picks which
            vdec_pkg::VWXUNARY0: begin
                vfu = vdec_pkg::VFU_MSK;
                op  = vdec_pkg::VALU_MOVE;
            end
            vdec_pkg::VMUL:   op = vdec_pkg::VALU_MUL;
            vdec_pkg::VMULHU: begin
                op         = vdec_pkg::VALU_MULH;
                opunsigned = 1'b1;
            end
            // Accumulate forms, addend is vd for macc/nmsac and vs2 for madd/nmsub
            vdec_pkg::VMACC:  op = vdec_pkg::VALU_ADD;
            vdec_pkg::VNMSAC: op = vdec_pkg::VALU_SUB;
            vdec_pkg::VMADD:  op = vdec_pkg::VALU_MADD;
            vdec_pkg::VNMSUB: op = vdec_pkg::VALU_NMSUB;
            // Widening adds run in the ALU at twice the sew
            vdec_pkg::VWADDU: begin
                vfu        = vdec_pkg::VFU_ALU;
                op         = vdec_pkg::VALU_ADD;
                opunsigned = 1'b1;
            end
            vdec_pkg::VWADD: begin
                vfu = vdec_pkg::VFU_ALU;
                op  = vdec_pkg::VALU_ADD;
            end
            default: valid = 1'b0;
        endcase
    end

endmodule

// File: design/vuop_gen.sv
// Micro-op sequencer, LANES elements per micro-op, LANES a power of two
// gen, veew and evl must stay stable while busy is high
`timescale 1ns/1ps

module vuop_gen #(
    parameter int  VLEN   = 128,
    parameter int  LANES  = 4,
    localparam int BANK_W = (VLEN / 8 / LANES > 1) ? $clog2(VLEN / 8 / LANES) : 1
) (
    input  logic                        CLK,
    input  logic                        reset,
    input  logic                        gen,
    input  logic                        stall,
    input  vdec_pkg::vsew_t             veew,
    input  logic [vdec_pkg::VL_W-1:0]   evl,
    output logic [vdec_pkg::VL_W-1:0]   uop_num,
    output logic [2:0]                  reg_offset,
    output logic [BANK_W-1:0]           bank_offset,
    output logic [LANES-1:0]            lane_active,
    output logic                        busy
);

    localparam int W = vdec_pkg::VL_W;
    localparam int LOG_LANES = $clog2(LANES);
    // log2 of elements per register at SEW8
    localparam int LOG_EPR8 = $clog2(VLEN / 8);

    logic [W-1:0] cnt;
    logic [W:0]   evl_up;
    logic [W-1:0] uop_cnt;
    logic         last;
    logic [W:0]   first_elem;
    logic [4:0]   epr_log2;
    logic [W:0]   epr_mask;
    logic [W:0]   reg_idx;
    logic [W:0]   in_reg;
    logic [W:0]   bank_idx;

    // ceil(evl/LANES), never below one
    assign evl_up  = {1'b0, evl} + (W + 1)'(LANES - 1);
    assign uop_cnt = (evl == '0) ? W'(1) : W'(evl_up >> LOG_LANES);
    assign last    = ({1'b0, cnt} + 1'b1) >= {1'b0, uop_cnt};
    assign busy    = gen && !last;

    // Element position of micro-op k inside the register group
    assign first_elem = {1'b0, cnt} << LOG_LANES;
    assign epr_log2   = 5'(LOG_EPR8) - {3'b000, veew};
    assign epr_mask   = ((W + 1)'(1) << epr_log2) - 1'b1;
    assign reg_idx    = first_elem >> epr_log2;
    assign in_reg     = first_elem & epr_mask;
    assign bank_idx   = in_reg >> LOG_LANES;

    assign uop_num     = cnt;
    assign reg_offset  = reg_idx[2:0];
    assign bank_offset = bank_idx[BANK_W-1:0];

    // Tail lanes past evl stay off
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lane_active[i] = gen && ((first_elem + (W + 1)'(i)) < {1'b0, evl});
        end
    end

    // Counter wraps to zero after the last micro-op, stall holds it
    always_ff @(posedge CLK) begin
        if (reset) begin
            cnt <= '0;
        end else if (!gen) begin
            cnt <= '0;
        end else if (!stall) begin
            cnt <= last ? '0 : cnt + 1'b1;
        end
    end

endmodule

// File: design/vcontrol_unit.sv
// Vector decode top, combinational from instr; no AMO, FP or segment loads
// instr, vsew and vl must be held while vbusy is high
`timescale 1ns/1ps

module vcontrol_unit #(
    parameter int  VLEN   = 128,
    parameter int  LANES  = 4,
    localparam int BANK_W = (VLEN / 8 / LANES > 1) ? $clog2(VLEN / 8 / LANES) : 1
) (
    input  logic                      CLK,
    input  logic                      reset,
    input  logic [31:0]               instr,
    input  vdec_pkg::vsew_t           vsew,
    input  logic [vdec_pkg::VL_W-1:0] vl,
    input  logic                      stall,
    output logic                      vvalid,
    output logic                      vbusy,
    output logic                      vmask_en,
    output vdec_pkg::vsetvl_t         vsetvl_type,
    output logic [10:0]               vtype_imm,
    output logic                      vkeepvl,
    output logic [4:0]                vd_sel,
    output logic [4:0]                vs1_sel,
    output logic [4:0]                vs2_sel,
    output logic                      sregwen,
    output logic                      vregwen,
    output logic                      vxin1_use_imm,
    output logic                      vxin1_use_rs1,
    output logic                      vxin2_use_rs2,
    output vdec_pkg::vsew_t           veew_src1,
    output vdec_pkg::vsew_t           veew_src2,
    output vdec_pkg::vsew_t           veew_dest,
    output vdec_pkg::vfu_t            vfu,
    output vdec_pkg::valuop_t         valuop,
    output logic                      vopunsigned,
    output logic                      vmemdren,
    output logic                      vmemdwen,
    output logic                      vunitstride,
    output logic                      vstrided,
    output logic                      vindexed,
    output logic [vdec_pkg::VL_W-1:0] evl,
    output logic [vdec_pkg::VL_W-1:0] uop_num,
    output logic [BANK_W-1:0]         bank_offset,
    output logic [LANES-1:0]          lane_active
);

    localparam int W = vdec_pkg::VL_W;

    // Instruction fields; vs3 of a store shares the vd slot
    logic [4:0] vd, vs1, vs2, vs3, rd, rs1;
    logic [2:0] nf;
    vdec_pkg::vmajor_t  vmajor;
    logic               vmajor_valid;
    vdec_pkg::vfunct3_t vfunct3;
    vdec_pkg::mop_t     mop;
    vdec_pkg::lumop_t   lumop;
    vdec_pkg::width_t   vmem_width;
    logic alu, vcfg, vmeminstr, opi_fmt, opm_fmt, vwidening, vnarrowing;
    logic vmaskldst, vwholereg, vexec_valid;
    vdec_pkg::vsew_t vmem_eew, twice_vsew;
    logic [W-1:0] mask_evl, wholereg_evl;
    logic [2:0] reg_offset;
    vdec_pkg::vfu_t    opi_fu, opm_fu;
    vdec_pkg::valuop_t opi_op, opm_op;
    logic opi_uns, opm_uns, opi_valid, opm_valid;

    assign vd  = instr[11:7];
    assign rd  = instr[11:7];
    assign vs3 = instr[11:7];
    assign vs1 = instr[19:15];
    assign rs1 = instr[19:15];
    assign vs2 = instr[24:20];
    assign nf  = instr[31:29];
    assign vfunct3    = vdec_pkg::vfunct3_t'(instr[14:12]);
    assign vmem_width = vdec_pkg::width_t'(instr[14:12]);
    assign mop        = vdec_pkg::mop_t'(instr[27:26]);
    assign lumop      = vdec_pkg::lumop_t'(instr[24:20]);
    assign vmask_en   = !instr[25];

    always_comb begin
        vmajor       = vdec_pkg::VMOC_NONE;
        vmajor_valid = 1'b1;
        case (instr[6:0])
            vdec_pkg::VMOC_LOAD:    vmajor = vdec_pkg::VMOC_LOAD;
            vdec_pkg::VMOC_STORE:   vmajor = vdec_pkg::VMOC_STORE;
            vdec_pkg::VMOC_ALU_CFG: vmajor = vdec_pkg::VMOC_ALU_CFG;
            // Not a vector instruction
            default:                vmajor_valid = 1'b0;
        endcase
    end

    assign alu     = (vmajor == vdec_pkg::VMOC_ALU_CFG);
    assign vcfg    = alu && (vfunct3 == vdec_pkg::OPCFG);
    assign opi_fmt = alu && (vfunct3 == vdec_pkg::OPIVV || vfunct3 == vdec_pkg::OPIVI ||
                             vfunct3 == vdec_pkg::OPIVX);
    assign opm_fmt = alu && (vfunct3 == vdec_pkg::OPMVV || vfunct3 == vdec_pkg::OPMVX);

    // vset* kind from the top bits, vsetvl has 1000000 in funct7
    always_comb begin
        vsetvl_type = vdec_pkg::NOT_CFG;
        vtype_imm   = '0;
        vkeepvl     = 1'b0;
        if (vcfg) begin
            if (!instr[31]) begin
                vsetvl_type = vdec_pkg::VSETVLI;
                vtype_imm   = instr[30:20];
                vkeepvl     = (rs1 == '0) && (rd == '0);
            end else if (instr[30]) begin
                vsetvl_type = vdec_pkg::VSETIVLI;
                vtype_imm   = {1'b0, instr[29:20]};
            end else begin
                vsetvl_type = vdec_pkg::VSETVL;
                vkeepvl     = (rs1 == '0) && (rd == '0);
            end
        end
    end

    // Memory kind, mop bits are funct6 bits for ALU ops so gate them
    assign vmemdren    = (vmajor == vdec_pkg::VMOC_LOAD);
    assign vmemdwen    = (vmajor == vdec_pkg::VMOC_STORE);
    assign vmeminstr   = vmemdren || vmemdwen;
    assign vunitstride = vmeminstr && (mop == vdec_pkg::MOP_UNIT);
    assign vstrided    = vmeminstr && (mop == vdec_pkg::MOP_STRIDED);
    assign vindexed    = vmeminstr && (mop == vdec_pkg::MOP_UINDEXED ||
                                       mop == vdec_pkg::MOP_OINDEXED);
    assign vmaskldst   = vunitstride && (lumop == vdec_pkg::LUMOP_UNIT_MASK);
    assign vwholereg   = vunitstride && (lumop == vdec_pkg::LUMOP_UNIT_FULLREG);

    // Scalar writes come from vset* and the OPMVV scalar move group
    assign sregwen = vcfg || (vfunct3 == vdec_pkg::OPMVV && alu &&
                              instr[31:26] == vdec_pkg::VWXUNARY0);
    assign vregwen = vvalid && !sregwen && !vmemdwen;

    // Operand routing, OPFVF only forwards the scalar
    assign vxin1_use_imm = alu && (vfunct3 == vdec_pkg::OPIVI);
    assign vxin1_use_rs1 = vmeminstr || (alu && (vfunct3 == vdec_pkg::OPIVX ||
                           vfunct3 == vdec_pkg::OPFVF || vfunct3 == vdec_pkg::OPMVX));
    // Stride value comes from rs2
    assign vxin2_use_rs2 = vstrided;

    // Effective element widths
    assign vmem_eew   = (vmem_width == vdec_pkg::WIDTH8)  ? vdec_pkg::SEW8 :
                        (vmem_width == vdec_pkg::WIDTH16) ? vdec_pkg::SEW16 : vdec_pkg::SEW32;
    assign twice_vsew = vdec_pkg::vsew_t'(vsew + 2'd1);
    assign vwidening  = opm_fmt && (instr[31:30] == 2'b11);
    assign vnarrowing = opi_fmt && (instr[31:28] == 4'b1011);

    // Indexed access: data uses vsew, index vector uses the width field
    assign veew_src1 = (vmeminstr && !vindexed) ? vmem_eew : vsew;
    assign veew_src2 = vindexed ? vmem_eew : vnarrowing ? twice_vsew : vsew;
    assign veew_dest = (vunitstride || vstrided) ? vmem_eew :
                       vindexed ? vsew : vwidening ? twice_vsew : vsew;

    // evl, nf holds NFIELDS-1 for whole-register access
    assign mask_evl     = (vl >> 3) + W'(|vl[2:0]);
    assign wholereg_evl = (W'({1'b0, nf} + 4'd1) << $clog2(VLEN / 8)) >> veew_dest;
    assign evl = vmaskldst ? mask_evl : vwholereg ? wholereg_evl : vl;

    vopi_decode u_opi (
        .funct6(vdec_pkg::vopi_t'(instr[31:26])), .vfu(opi_fu), .op(opi_op),
        .opunsigned(opi_uns), .valid(opi_valid)
    );

    vopm_decode u_opm (
        .funct6(vdec_pkg::vopm_t'(instr[31:26])), .vfu(opm_fu), .op(opm_op),
        .opunsigned(opm_uns), .valid(opm_valid)
    );

    // Exactly one source may claim the instruction, vset* has no exec op
    always_comb begin
        vfu         = vdec_pkg::VFU_ALU;
        valuop      = vdec_pkg::VALU_ADD;
        vopunsigned = 1'b0;
        vexec_valid = 1'b1;
        case ({opi_valid && opi_fmt, opm_valid && opm_fmt, vmeminstr})
            3'b100: begin
                vfu         = opi_fu;
                valuop      = opi_op;
                vopunsigned = opi_uns;
            end
            3'b010: begin
                vfu         = opm_fu;
                valuop      = opm_op;
                vopunsigned = opm_uns;
            end
            // Address generation as an unsigned add
            3'b001: vopunsigned = 1'b1;
            default: vexec_valid = vcfg;
        endcase
    end

    assign vvalid = vmajor_valid && vexec_valid;

    // Register selects step through the group per micro-op
    assign vd_sel  = vd + {2'b00, reg_offset};
    assign vs1_sel = (vmemdwen ? vs3 : vs1) + {2'b00, reg_offset};
    assign vs2_sel = vs2 + {2'b00, reg_offset};

    vuop_gen #(.VLEN(VLEN), .LANES(LANES)) u_uop_gen (
        .CLK(CLK), .reset(reset), .gen(vvalid), .stall(stall), .veew(veew_dest),
        .evl(evl), .uop_num(uop_num), .reg_offset(reg_offset),
        .bank_offset(bank_offset), .lane_active(lane_active), .busy(vbusy)
    );

endmodule

// File: sim/vdecode_tb.sv
// Drives vcontrol_unit with the cases and expected decode of sim/vdecode_cases.txt
// Micro-op fields follow from evl and veew_dest of each case under random stall
`timescale 1ns/1ps

module vdecode_tb;

    localparam int VLEN   = 128;
    localparam int LANES  = 4;
    localparam int BANK_W = (VLEN / 8 / LANES > 1) ? $clog2(VLEN / 8 / LANES) : 1;
    localparam int VL_W   = vdec_pkg::VL_W;
    localparam int NCOL   = 24;

    logic clk;
    logic reset;
    logic [31:0] instr;
    vdec_pkg::vsew_t vsew;
    logic [VL_W-1:0] vl;
    logic stall;
    logic vvalid, vbusy, vmask_en, vkeepvl, sregwen, vregwen;
    logic vxin1_use_imm, vxin1_use_rs1, vxin2_use_rs2, vopunsigned;
    logic vmemdren, vmemdwen, vunitstride, vstrided, vindexed;
    vdec_pkg::vsetvl_t vsetvl_type;
    logic [10:0] vtype_imm;
    logic [4:0] vd_sel, vs1_sel, vs2_sel;
    vdec_pkg::vsew_t veew_src1, veew_src2, veew_dest;
    vdec_pkg::vfu_t vfu;
    vdec_pkg::valuop_t valuop;
    logic [VL_W-1:0] evl, uop_num;
    logic [BANK_W-1:0] bank_offset;
    logic [LANES-1:0] lane_active;

    // Case table with the columns of the data file
    logic [31:0] tab [64][NCOL];
    logic [31:0] cur [NCOL];
    int ncases;
    int checks;
    int errors;
    int cycles;
    int limit;

    vcontrol_unit #(.VLEN(VLEN), .LANES(LANES)) dut_i (
        .CLK(clk), .reset(reset), .instr(instr), .vsew(vsew), .vl(vl), .stall(stall),
        .vvalid(vvalid), .vbusy(vbusy), .vmask_en(vmask_en), .vsetvl_type(vsetvl_type),
        .vtype_imm(vtype_imm), .vkeepvl(vkeepvl), .vd_sel(vd_sel), .vs1_sel(vs1_sel),
        .vs2_sel(vs2_sel), .sregwen(sregwen), .vregwen(vregwen),
        .vxin1_use_imm(vxin1_use_imm), .vxin1_use_rs1(vxin1_use_rs1),
        .vxin2_use_rs2(vxin2_use_rs2), .veew_src1(veew_src1), .veew_src2(veew_src2),
        .veew_dest(veew_dest), .vfu(vfu), .valuop(valuop), .vopunsigned(vopunsigned),
        .vmemdren(vmemdren), .vmemdwen(vmemdwen), .vunitstride(vunitstride),
        .vstrided(vstrided), .vindexed(vindexed), .evl(evl), .uop_num(uop_num),
        .bank_offset(bank_offset), .lane_active(lane_active)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog on clock cycles
    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run exceeded %0d cycles", limit);
            $display("sim failed");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        errors++;
        $display("** Error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_vl(input string name, input logic [VL_W-1:0] got,
                            input logic [VL_W-1:0] exp);
        checks++;
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_sew(input string name, input vdec_pkg::vsew_t got,
                             input vdec_pkg::vsew_t exp);
        checks++;
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_fu(input string name, input vdec_pkg::vfu_t got,
                            input vdec_pkg::vfu_t exp);
        checks++;
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_op(input string name, input vdec_pkg::valuop_t got,
                            input vdec_pkg::valuop_t exp);
        checks++;
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_cfg(input string name, input vdec_pkg::vsetvl_t got,
                             input vdec_pkg::vsetvl_t exp);
        checks++;
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    // Skips comment lines and reads one case per data line
    task automatic load_cases(output logic ok);
        int fd;
        int cnt;
        string line;
        logic [31:0] v [NCOL];
        ok = 1'b0;
        ncases = 0;
        fd = $fopen("sim/vdecode_cases.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0 && ncases < 64) begin
                if (line.len() > 1 && line[0] != "#") begin
                    cnt = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11],
                        v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20], v[21],
                        v[22], v[23]);
                    if (cnt == NCOL) begin
                        for (int j = 0; j < NCOL; j++) begin
                            tab[ncases][j] = v[j];
                        end
                        ncases++;
                    end
                end
            end
            $fclose(fd);
            ok = (ncases > 0);
        end
    endtask

    // ceil(evl/LANES) with a minimum of one, also the cycle count of an invalid case
    function automatic int uop_count(input logic [31:0] evl_exp);
        return (evl_exp == 0) ? 1 : int'((evl_exp + LANES - 1) / LANES);
    endfunction

    task automatic check_decode();
        check_bit("vvalid", vvalid, cur[3][0]);
        check_bit("vmask_en", vmask_en, !cur[0][25]);
        check_cfg("vsetvl_type", vsetvl_type, vdec_pkg::vsetvl_t'(cur[4][1:0]));
        check_vl("vtype_imm", VL_W'(vtype_imm), VL_W'(cur[5][10:0]));
        check_bit("vkeepvl", vkeepvl, cur[6][0]);
        check_bit("sregwen", sregwen, cur[7][0]);
        check_bit("vregwen", vregwen, cur[8][0]);
        check_fu("vfu", vfu, vdec_pkg::vfu_t'(cur[9][2:0]));
        check_op("valuop", valuop, vdec_pkg::valuop_t'(cur[10][3:0]));
        check_bit("vopunsigned", vopunsigned, cur[11][0]);
        check_bit("vxin1_use_imm", vxin1_use_imm, cur[12][0]);
        check_bit("vxin1_use_rs1", vxin1_use_rs1, cur[13][0]);
        check_bit("vxin2_use_rs2", vxin2_use_rs2, cur[14][0]);
        check_bit("vmemdren", vmemdren, cur[15][0]);
        check_bit("vmemdwen", vmemdwen, cur[16][0]);
        check_bit("vunitstride", vunitstride, cur[17][0]);
        check_bit("vstrided", vstrided, cur[18][0]);
        check_bit("vindexed", vindexed, cur[19][0]);
        check_sew("veew_src1", veew_src1, vdec_pkg::vsew_t'(cur[20][1:0]));
        check_sew("veew_src2", veew_src2, vdec_pkg::vsew_t'(cur[21][1:0]));
        check_sew("veew_dest", veew_dest, vdec_pkg::vsew_t'(cur[22][1:0]));
        check_vl("evl", evl, cur[23][VL_W-1:0]);
    endtask

    // Expected fields of micro-op k from evl and the destination eew
    task automatic check_uop(input int k, input int n);
        int epr;
        int first;
        logic [LANES-1:0] lanes;
        logic [4:0] roff;
        logic [4:0] vd_exp;
        logic [4:0] vs1_exp;
        logic [4:0] vs2_exp;
        epr = VLEN / (8 << int'(cur[22][1:0]));
        first = k * LANES;
        for (int i = 0; i < LANES; i++) begin
            lanes[i] = (first + i) < int'(cur[23]);
        end
        roff = 5'((first / epr) % 8);
        vd_exp = cur[0][11:7] + roff;
        // Store data vs3 sits in the vd field and is read on the first source port
        vs1_exp = (cur[16][0] ? cur[0][11:7] : cur[0][19:15]) + roff;
        vs2_exp = cur[0][24:20] + roff;
        check_vl("uop_num", uop_num, VL_W'(k));
        check_vl("bank_offset", VL_W'(bank_offset), VL_W'((first % epr) / LANES));
        check_vl("lane_active", VL_W'(lane_active), VL_W'(lanes));
        check_vl("vd_sel", VL_W'(vd_sel), VL_W'(vd_exp));
        check_vl("vs1_sel", VL_W'(vs1_sel), VL_W'(vs1_exp));
        check_vl("vs2_sel", VL_W'(vs2_sel), VL_W'(vs2_exp));
        check_bit("vbusy", vbusy, k != n - 1);
    endtask

    // Starts and ends right after a rising edge
    task automatic run_case(input int c);
        int n;
        int k;
        int e0;
        logic st;
        logic done;
        e0 = errors;
        for (int j = 0; j < NCOL; j++) begin
            cur[j] = tab[c][j];
        end
        n = uop_count(cur[23]);
        #1;
        instr = cur[0];
        vsew  = vdec_pkg::vsew_t'(cur[1][1:0]);
        vl    = cur[2][VL_W-1:0];
        stall = ($urandom % 4) == 0;
        #1;
        check_decode();
        if (!cur[3][0]) begin
            check_bit("vbusy", vbusy, 1'b0);
            check_vl("lane_active", VL_W'(lane_active), '0);
            @(posedge clk);
        end else begin
            k = 0;
            done = 1'b0;
            while (!done) begin
                check_uop(k, n);
                st = stall;
                done = !vbusy && !st;
                @(posedge clk);
                if (!st && !done) begin
                    k++;
                    if (k >= n) begin
                        errors++;
                        $display("busy still high after %0d micro-ops at %0t", n, $time);
                        done = 1'b1;
                    end
                end
                if (!done) begin
                    #1 stall = ($urandom % 4) == 0;
                    #1;
                end
            end
        end
        $display("case %0d instr %h: %s", c, cur[0], (errors == e0) ? "ok" : "FAILED");
    endtask

    initial begin
        logic ok;
        void'($urandom(32'h83b9_2fae));
        reset  = 1'b1;
        // A four micro-op vadd.vv stays on the inputs through reset with stall low
        instr  = 32'h0200_0057;
        vsew   = vdec_pkg::SEW8;
        vl     = VL_W'(4 * LANES);
        stall  = 1'b0;
        checks = 0;
        errors = 0;
        cycles = 0;
        limit  = 0;
        load_cases(ok);
        if (!ok) begin
            errors++;
            $display("could not read any case from sim/vdecode_cases.txt");
        end else begin
            limit = 60 + 4 * ncases;
            for (int c = 0; c < ncases; c++) begin
                limit += 2 * uop_count(tab[c][23]);
            end
            repeat (3) @(posedge clk);
            #1;
            reset = 1'b0;
            instr = '0;
            vl    = '0;
            #1;
            // Counter must still be at zero after the instruction held in reset
            check_bit("vbusy", vbusy, 1'b0);
            check_vl("uop_num", uop_num, '0);
            @(posedge clk);
            for (int c = 0; c < ncases; c++) begin
                run_case(c);
            end
        end
        $display("%0d cases, %0d checks, %0d errors", ncases, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim/vdecode_cases.txt
# instr vsew vl vvalid cfg imm keepvl sregwen vregwen fu op uns use_imm use_rs1 use_rs2
# dren dwen unit strided indexed eew_src1 eew_src2 eew_dest evl, all in hex
0d007057 2 0008 1 1 0d0 1 1 0 0 0 0 0 0 0 0 0 0 0 0 2 2 2 0008
c10272d7 0 0003 1 2 010 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0003
803170d7 1 0005 1 3 000 0 1 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 0005
003100b3 0 0004 0 0 000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0004
02860257 2 000b 1 0 000 0 0 1 0 0 0 0 0 0 0 0 0 0 0 2 2 2 000b
1021c0d7 0 0010 1 0 000 0 0 1 0 3 1 0 1 0 0 0 0 0 0 0 0 0 0010
a653b1d7 1 0006 1 0 000 0 0 1 0 9 0 1 0 0 0 0 0 0 0 1 1 1 0006
ba808157 0 0008 1 0 000 0 0 1 0 a 1 0 0 0 0 0 0 0 0 0 1 0 0008
3a434457 3 0005 1 0 000 0 0 1 4 8 0 0 1 0 0 0 0 0 0 3 3 3 0005
061080d7 0 0004 0 0 000 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0004
0242a357 2 0004 1 0 000 0 0 1 1 0 0 0 0 0 0 0 0 0 0 2 2 2 0004
423023d7 0 0001 1 0 000 0 1 0 3 f 0 0 0 0 0 0 0 0 0 0 0 0 0001
b621e257 1 0009 1 0 000 0 0 1 2 0 0 0 1 0 0 0 0 0 0 1 1 1 0009
c2222457 1 0008 1 0 000 0 0 1 0 0 1 0 0 0 0 0 0 0 0 1 1 2 0008
0202d107 2 0006 1 0 000 0 0 1 0 0 1 0 1 0 1 0 1 0 0 1 2 1 0006
0a20e1a7 0 0007 1 0 000 0 0 0 0 0 1 0 1 1 0 1 0 1 0 2 0 2 0007
04408407 1 0004 1 0 000 0 0 1 0 0 1 0 1 0 1 0 0 0 1 1 0 1 0004
02b10087 2 0013 1 0 000 0 0 1 0 0 1 0 1 0 1 0 1 0 0 0 2 0 0003
2281e207 0 0003 1 0 000 0 0 1 0 0 1 0 1 0 1 0 1 0 0 2 0 2 0008
62808407 3 0001 1 0 000 0 0 1 0 0 1 0 1 0 1 0 1 0 0 0 3 0 0040
02860257 2 0000 1 0 000 0 0 1 0 0 0 0 0 0 0 0 0 0 0 2 2 2 0000

// File: tb.f
design/vdec_pkg.sv
design/vopi_decode.sv
design/vopm_decode.sv
design/vuop_gen.sv
design/vcontrol_unit.sv
sim/vdecode_tb.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing -Wno-fatal -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := vdecode_tb
FILELIST   := tb.f
OBJ_DIR    := obj_dir
PASS_MSG   := sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
